// File: hdl/pdp8_pkg.sv
// processor-wide types for the pdp8_mini core; imported by every processor module.
`default_nettype none

package pdp8_pkg;

    typedef logic [11:0] word_t;
    typedef logic [11:0] addr_t;

    // bit 11 here is bit 0 in PDP-8 numbering.
    typedef enum logic [2:0]
    {
        OP_AND,
        OP_TAD,
        OP_ISZ,
        OP_DCA,
        OP_JMS,
        OP_JMP,
        OP_IOT,
        OP_OPR
    } opcode_t;

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_DEFER,
        ST_EXEC,
        ST_WRITE
    } cpu_state_t;

    typedef enum logic [2:0]
    {
        ALU_NONE,
        ALU_AND,
        ALU_TAD,
        ALU_DCA_CLEAR,
        ALU_GRP1,
        ALU_GRP2
    } alu_op_t;

    // ##############################
    // micro-op flags
    // ##############################
    typedef struct packed
    {
        logic cla;
        logic cll;
        logic cma;
        logic cml;
        logic iac;
        logic rar;
        logic ral;
        logic twice;    // rotate by two.
        logic bsw;
    } grp1_t;

    typedef struct packed
    {
        logic sma;
        logic sza;
        logic snl;
        logic reverse;
        logic cla;
        logic hlt;
    } grp2_t;

    typedef struct packed
    {
        opcode_t opcode;
        logic    indirect;
        addr_t   ea;
        logic    auto_index;
        logic    is_grp1;
        logic    is_grp2;
        grp1_t   grp1;
        grp2_t   grp2;
    } decoded_t;

    typedef struct packed
    {
        logic  valid;
        logic  write;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed
    {
        alu_op_t op;
        word_t   operand;
    } alu_cmd_t;

    localparam addr_t AUTO_INDEX_LO = 12'o0010;
    localparam addr_t AUTO_INDEX_HI = 12'o0017;
    localparam int    MEM_WORDS     = 4096;

endpackage

`default_nettype wire

// File: hdl/host_pkg.sv
// host command types for deposit, examine and run; imported by the host port and top level.
`default_nettype none

package host_pkg;

    import pdp8_pkg::*;

    typedef enum logic [1:0]
    {
        HOST_WRITE,
        HOST_READ,
        HOST_RUN
    } host_cmd_t;

    // addr is the start address for a run.
    typedef struct packed
    {
        host_cmd_t cmd;
        addr_t     addr;
        word_t     data;
    } host_req_t;

endpackage

`default_nettype wire

// File: hdl/core_memory.sv
// 4K x 12 core memory with registered read, shared by the processor and the host port.
`default_nettype none
`timescale 1ns/100ps

module core_memory
    import pdp8_pkg::*;
(
    input  logic     clk,
    input  mem_req_t cpu_req,
    input  mem_req_t host_mem_req,
    output word_t    rdata
);

    word_t    mem [MEM_WORDS];
    mem_req_t sel;

    // the two requesters are never valid in the same cycle.
    assign sel = cpu_req.valid ? cpu_req : host_mem_req;

    always_ff @(posedge clk)
    begin
        if (sel.valid)
        begin
            if (sel.write)
                mem[sel.addr] <= sel.wdata;
            rdata <= mem[sel.addr];    // old contents on a write.
        end
    end

endmodule

`default_nettype wire

// File: hdl/instr_decode.sv
// combinational instruction decode; maps the instruction word and pc to a decoded_t.
`default_nettype none
`timescale 1ns/100ps

module instr_decode
    import pdp8_pkg::*;
(
    input  word_t    ir,
    input  addr_t    pc,
    output decoded_t dec
);

    logic is_opr;

    assign is_opr = (ir[11:9] == OP_OPR);

    always_comb
    begin
        dec.opcode   = opcode_t'(ir[11:9]);
        dec.indirect = ir[8];
        // page bit selects current page or page zero.
        dec.ea = ir[7] ? {pc[11:7], ir[6:0]} : {5'b0, ir[6:0]};
        dec.auto_index = !is_opr && ir[8] &&
                         (dec.ea >= AUTO_INDEX_LO) && (dec.ea <= AUTO_INDEX_HI);
        dec.is_grp1 = is_opr && !ir[8];
        dec.is_grp2 = is_opr && ir[8] && !ir[0];    // ir[0] set is group 3, a no-op.
        dec.grp1 = '0;
        dec.grp2 = '0;

        // ##############################
        // operate micro-ops
        // ##############################
        if (dec.is_grp1)
        begin
            dec.grp1.cla   = ir[7];
            dec.grp1.cll   = ir[6];
            dec.grp1.cma   = ir[5];
            dec.grp1.cml   = ir[4];
            dec.grp1.rar   = ir[3];
            dec.grp1.ral   = ir[2];
            dec.grp1.twice = ir[1];
            dec.grp1.iac   = ir[0];
            dec.grp1.bsw   = ir[1] && !ir[3] && !ir[2];    // twice with no rotate.
        end
        if (dec.is_grp2)
        begin
            dec.grp2.cla     = ir[7];
            dec.grp2.sma     = ir[6];
            dec.grp2.sza     = ir[5];
            dec.grp2.snl     = ir[4];
            dec.grp2.reverse = ir[3];
            dec.grp2.hlt     = ir[1];
        end
    end

endmodule

`default_nettype wire

// File: hdl/major_state.sv
// major-state sequencer; owns pc, the instruction register and all memory cycles.
`default_nettype none
`timescale 1ns/100ps

module major_state
    import pdp8_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  addr_t    start_pc,
    input  decoded_t dec,
    input  word_t    rdata,
    input  logic     skip,
    input  word_t    ac,
    output word_t    ir,
    output mem_req_t mem_req,
    output alu_cmd_t alu_cmd,
    output addr_t    pc,
    output logic     halted
);

    cpu_state_t state;
    word_t      ir_q;
    addr_t      ea_q;
    logic       auto_q;
    word_t      ptr;
    word_t      isz_sum;
    logic       mem_ref;

    // the decoder sees the fetched word while it is still on rdata.
    assign ir      = (state == ST_DECODE) ? rdata : ir_q;
    assign ptr     = auto_q ? rdata + 12'd1 : rdata;
    assign isz_sum = rdata + 12'd1;
    assign mem_ref = (dec.opcode <= OP_JMS) || (dec.opcode == OP_JMP && dec.indirect);

    always_comb
    begin
        mem_req         = '0;
        alu_cmd.op      = ALU_NONE;
        alu_cmd.operand = rdata;
        case (state)
            ST_FETCH:
            begin
                mem_req.valid = 1'b1;
                mem_req.addr  = pc;
            end
            ST_DECODE:
            begin
                if (dec.is_grp1)
                    alu_cmd.op = ALU_GRP1;
                else if (dec.is_grp2)
                    alu_cmd.op = ALU_GRP2;
                mem_req.valid = mem_ref;    // operand or pointer.
                mem_req.addr  = dec.ea;
            end
            ST_DEFER:
            begin
                mem_req.valid = auto_q;     // auto-index write-back.
                mem_req.write = 1'b1;
                mem_req.addr  = ea_q;
                mem_req.wdata = ptr;
            end
            ST_EXEC:
            begin
                mem_req.valid = 1'b1;
                mem_req.addr  = ea_q;
            end
            ST_WRITE:
            begin
                mem_req.addr  = ea_q;
                mem_req.write = 1'b1;
                case (dec.opcode)
                    OP_AND: alu_cmd.op = ALU_AND;
                    OP_TAD: alu_cmd.op = ALU_TAD;
                    OP_ISZ:
                    begin
                        mem_req.valid = 1'b1;
                        mem_req.wdata = isz_sum;
                    end
                    OP_DCA:
                    begin
                        mem_req.valid = 1'b1;
                        mem_req.wdata = ac;
                        alu_cmd.op    = ALU_DCA_CLEAR;
                    end
                    OP_JMS:
                    begin
                        mem_req.valid = 1'b1;
                        mem_req.wdata = pc;    // return address.
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // ##############################
    // sequencing
    // ##############################
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state  <= ST_IDLE;
            pc     <= '0;
            halted <= 1'b1;
            ir_q   <= '0;
            ea_q   <= '0;
            auto_q <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        pc     <= start_pc;
                        halted <= 1'b0;
                        state  <= ST_FETCH;
                    end
                end
                ST_FETCH: state <= ST_DECODE;
                ST_DECODE:
                begin
                    ir_q   <= rdata;
                    ea_q   <= dec.ea;
                    auto_q <= dec.auto_index;
                    state  <= ST_FETCH;
                    if (dec.is_grp2 && skip)
                        pc <= pc + 12'd2;
                    else
                        pc <= pc + 12'd1;
                    if (dec.is_grp2 && dec.grp2.hlt)
                    begin
                        state  <= ST_IDLE;
                        halted <= 1'b1;
                    end
                    else if (dec.opcode == OP_JMP && !dec.indirect)
                        pc <= dec.ea;
                    else if (mem_ref)
                        state <= dec.indirect ? ST_DEFER : ST_WRITE;
                end
                ST_DEFER:
                begin
                    ea_q <= ptr;
                    if (dec.opcode == OP_JMP)
                    begin
                        pc    <= ptr;
                        state <= ST_FETCH;
                    end
                    else
                        state <= ST_EXEC;
                end
                ST_EXEC: state <= ST_WRITE;
                ST_WRITE:
                begin
                    if (dec.opcode == OP_ISZ && isz_sum == '0)
                        pc <= pc + 12'd1;
                    if (dec.opcode == OP_JMS)
                        pc <= ea_q + 12'd1;
                    state <= ST_FETCH;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/ac_result.sv
// accumulator and link unit; applies ALU commands and forms the group 2 skip.
`default_nettype none
`timescale 1ns/100ps

module ac_result
    import pdp8_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  alu_cmd_t alu_cmd,
    input  grp1_t    grp1,
    input  grp2_t    grp2,
    output word_t    ac,
    output logic     link,
    output logic     skip
);

    word_t       ac_next;
    logic        link_next;
    logic [12:0] lac;    // link above ac, so rotates pass through link.
    logic [12:0] sum;
    logic        cond;

    assign sum  = {1'b0, ac} + {1'b0, alu_cmd.operand};
    assign cond = (grp2.sma && ac[11]) || (grp2.sza && ac == '0) || (grp2.snl && link);
    assign skip = cond ^ grp2.reverse;

    // ##############################
    // group 1 in sequence order
    // ##############################
    always_comb
    begin
        lac = {grp1.cll ? 1'b0 : link, grp1.cla ? 12'd0 : ac};
        if (grp1.cma)
            lac[11:0] = ~lac[11:0];
        if (grp1.cml)
            lac[12] = ~lac[12];
        if (grp1.iac)
            lac = lac + 13'd1;    // carry out complements link.
        if (grp1.rar)
            lac = {lac[0], lac[12:1]};
        if (grp1.rar && grp1.twice)
            lac = {lac[0], lac[12:1]};
        if (grp1.ral)
            lac = {lac[11:0], lac[12]};
        if (grp1.ral && grp1.twice)
            lac = {lac[11:0], lac[12]};
        if (grp1.bsw)
            lac[11:0] = {lac[5:0], lac[11:6]};
    end

    always_comb
    begin
        ac_next   = ac;
        link_next = link;
        case (alu_cmd.op)
            ALU_AND: ac_next = ac & alu_cmd.operand;
            ALU_TAD:
            begin
                ac_next   = sum[11:0];
                link_next = link ^ sum[12];
            end
            ALU_DCA_CLEAR: ac_next = '0;
            ALU_GRP1: {link_next, ac_next} = lac;
            ALU_GRP2:
            begin
                if (grp2.cla)
                    ac_next = '0;    // after the skip test.
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ac   <= '0;
            link <= 1'b0;
        end
        else
        begin
            ac   <= ac_next;
            link <= link_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/host_port.sv
// host port FSM; runs the four-phase req/ack handshake for deposit, examine and run.
`default_nettype none
`timescale 1ns/100ps

module host_port
    import pdp8_pkg::*, host_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      req,
    input  host_req_t host_req,
    output logic      ack,
    output word_t     host_rdata,
    input  logic      halted,
    output mem_req_t  mem_req,
    input  word_t     rdata,
    output logic      start,
    output addr_t     start_pc
);

    typedef enum logic [2:0]
    {
        HP_IDLE,
        HP_ACCESS,
        HP_DATA,
        HP_ACK,
        HP_DONE
    } hp_state_t;

    hp_state_t state;
    logic      is_run;

    assign is_run   = (host_req.cmd == HOST_RUN);
    assign ack      = (state == HP_ACK) || (state == HP_DONE);
    assign start    = (state == HP_ACCESS) && is_run;
    assign start_pc = host_req.addr;

    always_comb
    begin
        mem_req.valid = (state == HP_ACCESS) && !is_run;
        mem_req.write = (host_req.cmd == HOST_WRITE);
        mem_req.addr  = host_req.addr;
        mem_req.wdata = host_req.data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= HP_IDLE;
        else
        begin
            case (state)
                HP_IDLE:
                begin
                    if (req && halted)    // held off while a program runs.
                        state <= HP_ACCESS;
                end
                HP_ACCESS: state <= is_run ? HP_ACK : HP_DATA;
                HP_DATA: state <= HP_ACK;
                HP_ACK:
                begin
                    if (!req)
                        state <= HP_DONE;
                end
                HP_DONE: state <= HP_IDLE;
                default: state <= HP_IDLE;
            endcase
        end
    end

    // read data lands on rdata during HP_DATA.
    always_ff @(posedge clk)
    begin
        if (state == HP_DATA)
            host_rdata <= rdata;
    end

endmodule

`default_nettype wire

// File: hdl/pdp8_mini_top.sv
// pdp8_mini top level; wires host port, core memory, decoder, sequencer and ac unit.
`default_nettype none
`timescale 1ns/100ps

module pdp8_mini_top
    import pdp8_pkg::*, host_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      req,
    input  host_req_t host_req,
    output logic      ack,
    output word_t     host_rdata,
    output word_t     ac,
    output logic      link,
    output addr_t     pc,
    output logic      halted
);

    mem_req_t host_mem_req;
    mem_req_t cpu_mem_req;
    word_t    rdata;
    logic     start;
    addr_t    start_pc;
    word_t    ir;
    decoded_t dec;
    alu_cmd_t alu_cmd;
    logic     skip;

    host_port host_port_i (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .host_req   (host_req),
        .ack        (ack),
        .host_rdata (host_rdata),
        .halted     (halted),
        .mem_req    (host_mem_req),
        .rdata      (rdata),
        .start      (start),
        .start_pc   (start_pc)
    );

    core_memory core_memory_i (
        .clk          (clk),
        .cpu_req      (cpu_mem_req),
        .host_mem_req (host_mem_req),
        .rdata        (rdata)
    );

    instr_decode instr_decode_i (
        .ir  (ir),
        .pc  (pc),
        .dec (dec)
    );

    major_state major_state_i (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .start_pc (start_pc),
        .dec      (dec),
        .rdata    (rdata),
        .skip     (skip),
        .ac       (ac),
        .ir       (ir),
        .mem_req  (cpu_mem_req),
        .alu_cmd  (alu_cmd),
        .pc       (pc),
        .halted   (halted)
    );

    ac_result ac_result_i (
        .clk     (clk),
        .reset   (reset),
        .alu_cmd (alu_cmd),
        .grp1    (dec.grp1),
        .grp2    (dec.grp2),
        .ac      (ac),
        .link    (link),
        .skip    (skip)
    );

endmodule

`default_nettype wire

// File: include/pdp8_ref_model.svh
// instruction-level PDP-8 interpreter; included inside the testbench module to predict results.
`ifndef PDP8_REF_MODEL_SVH
`define PDP8_REF_MODEL_SVH

typedef struct packed
{
    word_t ac;
    logic  link;
    addr_t pc;
    logic  halted;
} machine_t;

word_t ref_mem [MEM_WORDS];    // image the interpreter runs on.

// runs from start until HLT or max_steps instructions.
function automatic machine_t run_model(input addr_t start, input int max_steps);
    machine_t    m;
    word_t       ir;
    addr_t       ea;
    addr_t       nxt;
    logic [12:0] sum;
    logic        cond;
    int          step;
    int          n;
    m    = '0;
    m.pc = start;
    for (step = 0; step < max_steps && !m.halted; step++)
    begin
        ir  = ref_mem[m.pc];
        nxt = m.pc + 12'd1;
        ea  = {(ir[7] ? m.pc[11:7] : 5'd0), ir[6:0]};
        if (ir[11:9] < 3'd6 && ir[8])
        begin
            if (ea >= AUTO_INDEX_LO && ea <= AUTO_INDEX_HI)
                ref_mem[ea] = ref_mem[ea] + 12'd1;    // pre-increment.
            ea = ref_mem[ea];
        end
        case (ir[11:9])
            3'd0: m.ac = m.ac & ref_mem[ea];
            3'd1:
            begin
                sum    = {1'b0, m.ac} + {1'b0, ref_mem[ea]};
                m.ac   = sum[11:0];
                m.link = m.link ^ sum[12];
            end
            3'd2:
            begin
                ref_mem[ea] = ref_mem[ea] + 12'd1;
                if (ref_mem[ea] == 12'd0)
                    nxt = nxt + 12'd1;
            end
            3'd3:
            begin
                ref_mem[ea] = m.ac;
                m.ac        = '0;
            end
            3'd4:
            begin
                ref_mem[ea] = nxt;
                nxt         = ea + 12'd1;
            end
            3'd5: nxt = ea;
            3'd7:
            begin
                if (!ir[8])
                begin
                    if (ir[7])
                        m.ac = '0;
                    if (ir[6])
                        m.link = 1'b0;
                    if (ir[5])
                        m.ac = ~m.ac;
                    if (ir[4])
                        m.link = ~m.link;
                    if (ir[0])
                    begin
                        if (m.ac == 12'o7777)
                            m.link = ~m.link;
                        m.ac = m.ac + 12'd1;
                    end
                    n = ir[1] ? 2 : 1;
                    if (ir[3])
                        repeat (n) {m.link, m.ac} = {m.ac[0], m.link, m.ac[11:1]};
                    if (ir[2])
                        repeat (n) {m.link, m.ac} = {m.ac, m.link};
                    if (ir[1] && !ir[3] && !ir[2])
                        m.ac = {m.ac[5:0], m.ac[11:6]};    // byte swap.
                end
                else if (!ir[0])
                begin
                    cond = (ir[6] && m.ac[11]) || (ir[5] && m.ac == '0) || (ir[4] && m.link);
                    if (cond != ir[3])
                        nxt = nxt + 12'd1;
                    if (ir[7])
                        m.ac = '0;
                    if (ir[1])
                        m.halted = 1'b1;
                end
            end
            default: ;    // IOT does nothing here.
        endcase
        m.pc = nxt;
    end
    return m;
endfunction

`endif

// File: sim/tb_pdp8_mini.sv
// testbench for pdp8_mini_top; loads programs over the host port and checks them against a model.
`default_nettype none
`timescale 1ns/100ps

module tb_pdp8_mini
    import pdp8_pkg::*, host_pkg::*;
;

    localparam int HANDSHAKE_LIMIT = 50;
    localparam int RUN_LIMIT       = 20000;
    localparam int MODEL_STEPS     = 10000;

    // TAD/AND/DCA, indirect, auto-index, ISZ loop, JMS and JMP I, from 0200.
    localparam word_t MEMREF_PROG [15] = '{
        12'o7300, 12'o1250, 12'o1251, 12'o0252, 12'o3253, 12'o1654, 12'o3410, 12'o2256,
        12'o5207, 12'o4230, 12'o3261, 12'o5662, 12'o1410, 12'o1253, 12'o7402
    };
    localparam word_t GRP1_OPS [10] = '{
        12'o7200, 12'o7100, 12'o7040, 12'o7020, 12'o7001,
        12'o7004, 12'o7010, 12'o7006, 12'o7012, 12'o7002
    };
    localparam word_t SKIP_OPS [6] = '{
        12'o7500, 12'o7510, 12'o7440, 12'o7450, 12'o7420, 12'o7430
    };

    logic      clk;
    logic      reset;
    logic      req;
    host_req_t host_req;
    logic      ack;
    word_t     host_rdata;
    word_t     ac;
    logic      link;
    addr_t     pc;
    logic      halted;

    word_t image [MEM_WORDS];    // everything the host has deposited.
    addr_t used [$];
    word_t exp_q [$];
    word_t got_q [$];
    string what_q [$];
    int    queued;
    int    compared;
    int    seed;
    word_t cmp_exp;
    word_t cmp_got;
    string cmp_what;

    `include "pdp8_ref_model.svh"

    pdp8_mini_top pdp8_mini_top_i (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .host_req   (host_req),
        .ack        (ack),
        .host_rdata (host_rdata),
        .ac         (ac),
        .link       (link),
        .pc         (pc),
        .halted     (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic expect_word(input word_t got, input word_t exp, input string what);
        got_q.push_back(got);
        exp_q.push_back(exp);
        what_q.push_back(what);
        queued++;
    endtask

    // current-page direct memory-reference instruction.
    function automatic word_t mri(input logic [2:0] op, input addr_t target);
        return {op, 1'b0, 1'b1, target[6:0]};
    endfunction

    // ##############################
    // host handshake
    // ##############################
    task automatic wait_ack(input logic level, input int limit);
        int n;
        n = 0;
        while (ack !== level && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        assert (ack === level)
        else
            abort_run($sformatf("timeout: ack did not go to %0b", level));
    endtask

    task automatic host_handshake(input host_cmd_t cmd, input addr_t addr, input word_t data,
                                  output word_t rd);
        @(negedge clk);
        host_req.cmd  = cmd;
        host_req.addr = addr;
        host_req.data = data;
        req           = 1'b1;
        wait_ack(1'b1, HANDSHAKE_LIMIT);
        rd  = host_rdata;    // valid while ack is high.
        req = 1'b0;
        wait_ack(1'b0, HANDSHAKE_LIMIT);
    endtask

    task automatic host_write(input addr_t addr, input word_t data);
        word_t unused;
        host_handshake(HOST_WRITE, addr, data, unused);
        image[addr] = data;
    endtask

    task automatic host_read(input addr_t addr, output word_t data);
        host_handshake(HOST_READ, addr, 12'o0000, data);
    endtask

    task automatic host_run(input addr_t addr);
        word_t unused;
        host_handshake(HOST_RUN, addr, 12'o0000, unused);
    endtask

    task automatic wait_halt();
        int n;
        n = 0;
        while (halted !== 1'b1 && n < RUN_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        assert (halted === 1'b1)
        else
            abort_run("timeout: program did not halt");
    endtask

    // ##############################
    // programs and checking
    // ##############################
    task automatic deposit(input addr_t addr, input word_t data);
        host_write(addr, data);
        used.push_back(addr);
    endtask

    task automatic model_run(input addr_t start, output machine_t m);
        int a;
        for (a = 0; a < MEM_WORDS; a++)
            ref_mem[a] = image[a];
        m = run_model(start, MODEL_STEPS);
        assert (m.halted === 1'b1)
        else
            abort_run("reference model did not reach HLT");
    endtask

    task automatic check_program(input addr_t start, input string name);
        machine_t m;
        word_t    rd;
        model_run(start, m);
        host_run(start);
        wait_halt();
        expect_word(ac, m.ac, {name, " ac"});
        expect_word({11'd0, link}, {11'd0, m.link}, {name, " link"});
        expect_word(pc, m.pc, {name, " pc"});
        foreach (used[i])
        begin
            host_read(used[i], rd);
            expect_word(rd, ref_mem[used[i]], $sformatf("%s mem[%04o]", name, used[i]));
        end
        used.delete();
    endtask

    task automatic load_memref(input word_t a, input word_t b, input word_t mask, input word_t c);
        addr_t k;
        for (k = 0; k < 15; k++)
            deposit(12'o0200 + k, MEMREF_PROG[k]);
        deposit(12'o0010, 12'o0257);    // auto-index pointer.
        deposit(12'o0230, 12'o0000);
        deposit(12'o0231, 12'o7001);
        deposit(12'o0232, 12'o5630);
        deposit(12'o0250, a);
        deposit(12'o0251, b);
        deposit(12'o0252, mask);
        deposit(12'o0253, 12'o0000);
        deposit(12'o0254, 12'o0255);
        deposit(12'o0255, c);
        deposit(12'o0256, 12'o7776);    // ISZ loop runs twice.
        deposit(12'o0260, 12'o0000);
        deposit(12'o0261, 12'o0000);
        deposit(12'o0262, 12'o0214);
    endtask

    // examine issued while a program runs must wait for halted.
    task automatic held_examine(input addr_t addr, input word_t exp);
        logic saw_busy;
        int   n;
        @(negedge clk);
        host_req.cmd  = HOST_READ;
        host_req.addr = addr;
        host_req.data = 12'o0000;
        req           = 1'b1;
        saw_busy      = 1'b0;
        n             = 0;
        while (ack !== 1'b1 && n < RUN_LIMIT)
        begin
            if (halted === 1'b0)
                saw_busy = 1'b1;
            @(negedge clk);
            n++;
            assert (ack !== 1'b1 || halted === 1'b1)
            else
                abort_run("ack rose while the processor was still running");
        end
        assert (ack === 1'b1)
        else
            abort_run("timeout: held examine was never acknowledged");
        assert (saw_busy)
        else
            abort_run("program halted before the examine was issued");
        expect_word(host_rdata, exp, "held examine data");
        req = 1'b0;
        wait_ack(1'b0, HANDSHAKE_LIMIT);
    endtask

    // compare process.
    always @(posedge clk)
    begin
        while (got_q.size() > 0)
        begin
            cmp_got  = got_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            cmp_what = what_q.pop_front();
            compared++;
            assert (cmp_got === cmp_exp)
            else
                abort_run($sformatf("MISMATCH at %0t ns: %s expected %04o got %04o",
                                    $time, cmp_what, cmp_exp, cmp_got));
        end
    end

    initial
    begin
        machine_t m;
        addr_t    addrs [64];
        addr_t    k;
        addr_t    base;
        word_t    rd;
        int       n;
        seed     = 42;
        queued   = 0;
        compared = 0;
        reset    = 1'b1;
        req      = 1'b0;
        host_req = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        expect_word(pc, 12'o0000, "pc after reset");
        expect_word(ac, 12'o0000, "ac after reset");
        expect_word({11'd0, link}, 12'o0000, "link after reset");
        expect_word({11'd0, halted}, 12'o0001, "halted after reset");
        expect_word({11'd0, ack}, 12'o0000, "ack after reset");

        // deposit and examine
        for (k = 0; k < 64; k++)
        begin
            addrs[k] = addr_t'($random(seed));
            host_write(addrs[k], word_t'($random(seed)));
        end
        for (k = 0; k < 64; k++)
        begin
            host_read(addrs[k], rd);
            expect_word(rd, image[addrs[k]], $sformatf("examine %04o", addrs[k]));
        end

        load_memref(12'o1234, 12'o6600, 12'o7070, 12'o0777);
        check_program(12'o0200, "memref");

        // group 1 as TAD value, micro-op and DCA result
        deposit(12'o0300, 12'o7300);
        for (k = 0; k < 10; k++)
        begin
            deposit(12'o0301 + 12'd3 * k, mri(3'd1, 12'o0340 + k));
            deposit(12'o0302 + 12'd3 * k, GRP1_OPS[k]);
            deposit(12'o0303 + 12'd3 * k, mri(3'd3, 12'o0360 + k));
            deposit(12'o0340 + k, word_t'($random(seed)));
            deposit(12'o0360 + k, 12'o0000);
        end
        deposit(12'o0337, 12'o7402);
        check_program(12'o0300, "group 1");

        // group 2 with an ISZ after each skip recording that it was not skipped
        for (k = 0; k < 18; k++)
        begin
            base = 12'o0400 + 12'd5 * k;
            deposit(base, 12'o7300);
            deposit(base + 12'd1, mri(3'd1, 12'o0570 + k % 3));
            deposit(base + 12'd2, (k % 3 == 2) ? 12'o7020 : 12'o7000);
            deposit(base + 12'd3, SKIP_OPS[k / 3]);
            deposit(base + 12'd4, mri(3'd2, 12'o0540 + k));
            deposit(12'o0540 + k, 12'o0000);
        end
        deposit(12'o0532, 12'o7402);
        deposit(12'o0570, 12'o0123);
        deposit(12'o0571, 12'o0000);
        deposit(12'o0572, 12'o4567);
        check_program(12'o0400, "group 2");

        // back-pressure behind a 64-pass ISZ loop
        deposit(12'o0600, 12'o7300);
        deposit(12'o0601, mri(3'd2, 12'o0620));
        deposit(12'o0602, mri(3'd5, 12'o0601));
        deposit(12'o0603, 12'o7402);
        deposit(12'o0620, 12'o7700);
        model_run(12'o0600, m);
        host_run(12'o0600);
        held_examine(12'o0620, ref_mem[12'o0620]);
        used.delete();

        for (k = 0; k < 10; k++)
        begin
            load_memref(word_t'($random(seed)), word_t'($random(seed)),
                        word_t'($random(seed)), word_t'($random(seed)));
            check_program(12'o0200, $sformatf("random run %0d", k));
        end

        n = 0;
        while (compared != queued && n < HANDSHAKE_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (compared == queued && queued > 0)
        begin
            $display("Test passed");
            $finish;
        end
        else
            abort_run("not every queued result was compared");
    end

endmodule

`default_nettype wire

// File: pdp8_mini.f
+incdir+include
hdl/pdp8_pkg.sv
hdl/host_pkg.sv
hdl/core_memory.sv
hdl/instr_decode.sv
hdl/major_state.sv
hdl/ac_result.sv
hdl/host_port.sv
hdl/pdp8_mini_top.sv
sim/tb_pdp8_mini.sv

// File: Bender.yml
package:
  name: pdp8_mini

sources:
  - target: rtl
    files:
      - hdl/pdp8_pkg.sv
      - hdl/host_pkg.sv
      - hdl/core_memory.sv
      - hdl/instr_decode.sv
      - hdl/major_state.sv
      - hdl/ac_result.sv
      - hdl/host_port.sv
      - hdl/pdp8_mini_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_pdp8_mini.sv
